// ==== tb.f ====
video_pkg.sv
ctrl_pkg.sv
video_timing_if.sv
pixel_stream_if.sv
video_timing.sv
io_latch.sv
priority_mixer.sv
colour_palette.sv
performan_video.sv
tb_performan_video.sv

// ==== tb_performan_video.sv ====
/*
 * Directed testbench for the video back end. Runs reset, raster timing,
 * palette priority, blanking and scroll checks against a palette model.
 */
`timescale 1ns/1ps

module tb_performan_video
	import video_pkg::*, ctrl_pkg::*;
();

	localparam int      CLK_PERIOD  = 10;
	localparam int      NUM_TESTS   = 5;
	localparam longint  FRAME_NS    = longint'(H_TOTAL_DEF) * V_TOTAL_DEF * CLK_PERIOD;
	localparam longint  WATCHDOG_NS = (NUM_TESTS * 4 + 2) * FRAME_NS; // Four frames a test
	localparam [31:0]   SEED        = 32'hacad5a90;

	logic        pixel_clk = 1'b0;
	logic        RESET_n;
	logic        reg_wr_i;
	logic [2:0]  reg_addr_i;
	reg_data_t   reg_data_i;
	logic [9:0]  dn_addr_i;
	channel_t    dn_data_i;
	logic        dn_wr_i;
	pix_t        bg_pix_i;
	pix_t        sp_pix_i;
	hcount_t     hpix_scrl_o;
	channel_t    red_o;
	channel_t    green_o;
	channel_t    blue_o;
	logic        hsync_o;
	logic        vsync_o;
	logic        hblank_o;
	logic        vblank_o;

	logic [11:0] pal_model [256]; // Expected palette contents
	int          error_count = 0;

	always #(CLK_PERIOD / 2) pixel_clk = ~pixel_clk;

	performan_video i_performan_video (
		.pixel_clk   (pixel_clk),
		.RESET_n     (RESET_n),
		.reg_wr_i    (reg_wr_i),
		.reg_addr_i  (reg_addr_i),
		.reg_data_i  (reg_data_i),
		.dn_addr_i   (dn_addr_i),
		.dn_data_i   (dn_data_i),
		.dn_wr_i     (dn_wr_i),
		.bg_pix_i    (bg_pix_i),
		.sp_pix_i    (sp_pix_i),
		.hpix_scrl_o (hpix_scrl_o),
		.red_o       (red_o),
		.green_o     (green_o),
		.blue_o      (blue_o),
		.hsync_o     (hsync_o),
		.vsync_o     (vsync_o),
		.hblank_o    (hblank_o),
		.vblank_o    (vblank_o)
	);

	// ==============================
	// Helpers
	// ==============================
	task automatic check_value(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else begin
			error_count++;
			$display("CHECK FAILED %s: expected %0h, actual %0h", test, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic host_write(input reg_op_e op, input reg_data_t data);
		@(posedge pixel_clk);
		reg_wr_i   <= 1'b1;
		reg_addr_i <= op;
		reg_data_i <= data;
		@(posedge pixel_clk);
		reg_wr_i   <= 1'b0;
	endtask

	// One strobe per plane with red first
	task automatic load_entry(input colour_idx_t idx, input logic [11:0] colour);
		for (int p = 0; p < 3; p++) begin
			@(posedge pixel_clk);
			dn_wr_i   <= 1'b1;
			dn_addr_i <= {2'(p), idx};
			dn_data_i <= colour[11 - 4 * p -: 4];
		end
		@(posedge pixel_clk);
		dn_wr_i <= 1'b0;
	endtask

	function automatic logic probe(input int sel);
		case (sel)
			0:       probe = hsync_o;
			1:       probe = hblank_o;
			2:       probe = vsync_o;
			default: probe = vblank_o;
		endcase
	endfunction

	// Sprite wins if opaque and either priority or background transparent
	function automatic logic [11:0] expected_rgb(input pix_t bg, input pix_t sp);
		colour_idx_t idx;
		if ((sp[2:0] != 3'b000) && (sp[7] || (bg[2:0] == 3'b000)))
			idx = {1'b1, sp[6:0]};
		else
			idx = bg;
		return pal_model[idx];
	endfunction

	// Counts high samples and rise to rise spacing in cycles or in lines
	task automatic measure_pulse(input int sel, input bit in_lines,
		output int width, output int period);
		logic prev;
		logic hs_prev;
		width  = 0;
		period = 0;
		do begin
			prev = probe(sel);
			@(negedge pixel_clk);
		end while (!(probe(sel) && !prev));
		hs_prev = hsync_o;
		do begin
			if (!in_lines || (hsync_o && !hs_prev)) begin
				period++;
				if (probe(sel))
					width++;
			end
			prev    = probe(sel);
			hs_prev = hsync_o;
			@(negedge pixel_clk);
		end while (!(probe(sel) && !prev));
	endtask

	// Next active line after a blank so that new pixels have flushed through
	task automatic wait_active_line();
		do begin
			@(negedge pixel_clk);
		end while (!hblank_o);
		do begin
			@(negedge pixel_clk);
		end while (hblank_o || vblank_o);
	endtask

	task automatic check_scroll_line(input string name, input int first, input int step);
		hcount_t back1;
		hcount_t back2;
		do begin
			@(negedge pixel_clk);
		end while (!hblank_o);
		back1 = hpix_scrl_o;
		back2 = hpix_scrl_o;
		do begin
			back2 = back1;
			back1 = hpix_scrl_o;
			@(negedge pixel_clk);
		end while (hblank_o);
		// back2 now holds the column of the first unblanked pixel
		for (int k = 0; k < 32; k++) begin
			check_value(name, hcount_t'(first + step * k), back2);
			back2 = back1;
			back1 = hpix_scrl_o;
			@(negedge pixel_clk);
		end
	endtask

	// ==============================
	// Tests
	// ==============================
	task automatic reset_state();
		RESET_n <= 1'b0;
		repeat (16) begin
			@(negedge pixel_clk);
			check_value("reset_state", 0,
				{red_o, green_o, blue_o, hsync_o, vsync_o, hblank_o, vblank_o});
			@(posedge pixel_clk);
		end
		RESET_n <= 1'b1;
		@(negedge pixel_clk);
		check_value("reset_state", 0, {red_o, green_o, blue_o});
		repeat (64) begin
			check_value("reset_state", 0, {hsync_o, vsync_o, hblank_o, vblank_o});
			@(negedge pixel_clk);
		end
	endtask

	task automatic sync_timing();
		int width;
		int period;
		measure_pulse(0, 1'b0, width, period);
		check_value("sync_timing hsync period", H_TOTAL_DEF, period);
		check_value("sync_timing hsync width", H_SYNC_END_DEF - H_SYNC_START_DEF, width);
		measure_pulse(1, 1'b0, width, period);
		check_value("sync_timing hblank width", H_TOTAL_DEF - H_ACTIVE_DEF, width);
		measure_pulse(2, 1'b1, width, period);
		check_value("sync_timing vsync lines", V_TOTAL_DEF, period);
		check_value("sync_timing vsync width", 8, width);
		measure_pulse(3, 1'b1, width, period);
		check_value("sync_timing vblank lines", V_TOTAL_DEF - V_ACTIVE_DEF, width);
	endtask

	task automatic palette_priority();
		logic [11:0] colour;
		pix_t        bg;
		pix_t        sp;
		for (int i = 0; i < 256; i++) begin
			colour       = 12'($urandom);
			pal_model[i] = colour;
			load_entry(colour_idx_t'(i), colour);
		end
		host_write(REG_VIDEO_EN, 8'h01);
		repeat (12) begin
			bg = pix_t'($urandom);
			sp = pix_t'($urandom);
			@(posedge pixel_clk);
			bg_pix_i <= bg;
			sp_pix_i <= sp;
			wait_active_line();
			repeat (32) begin
				check_value("palette_priority", expected_rgb(bg, sp), {red_o, green_o, blue_o});
				@(negedge pixel_clk);
			end
		end
	endtask

	task automatic blanking_and_enable();
		logic [11:0] colour;
		colour       = 12'($urandom) | 12'h100; // Red never zero
		pal_model[0] = colour;
		load_entry(8'h00, colour);
		@(posedge pixel_clk);
		bg_pix_i <= pix_t'($urandom) | 8'h01;
		sp_pix_i <= 8'h00;
		wait_active_line();
		do begin
			@(negedge pixel_clk);
		end while (!hblank_o);
		while (hblank_o) begin
			check_value("blanking_and_enable hblank", colour, {red_o, green_o, blue_o});
			@(negedge pixel_clk);
		end
		do begin
			@(negedge pixel_clk);
		end while (!vblank_o);
		repeat (2 * H_TOTAL_DEF) begin
			check_value("blanking_and_enable vblank", colour, {red_o, green_o, blue_o});
			@(negedge pixel_clk);
		end
		host_write(REG_VIDEO_EN, 8'h00);
		wait_active_line();
		repeat (H_ACTIVE_DEF) begin
			check_value("blanking_and_enable disabled", colour, {red_o, green_o, blue_o});
			@(negedge pixel_clk);
		end
	endtask

	task automatic scroll_and_flip();
		hcount_t scroll;
		scroll = hcount_t'($urandom);
		host_write(REG_HSCROLL_LO, scroll[7:0]);
		host_write(REG_HSCROLL_HI, {7'b0, scroll[8]});
		host_write(REG_FLIP, 8'h00);
		check_scroll_line("scroll_and_flip normal", scroll, 1);
		host_write(REG_FLIP, 8'h01);
		check_scroll_line("scroll_and_flip flipped", scroll + 255, -1);
	endtask

	// ==============================
	// Run
	// ==============================
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all tests finished");
		$display("Simulation failed");
		$fatal(1, "Timeout");
	end

	initial begin
		void'($urandom(SEED));
		RESET_n    = 1'b0;
		reg_wr_i   = 1'b0;
		reg_addr_i = '0;
		reg_data_i = '0;
		dn_addr_i  = '0;
		dn_data_i  = '0;
		dn_wr_i    = 1'b0;
		bg_pix_i   = '0;
		sp_pix_i   = '0;
		reset_state();
		sync_timing();
		palette_priority();
		blanking_and_enable();
		scroll_and_flip();
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== performan_video.sv ====
/*
 * Video back end top level. Counters feed the scroll output and the mixer,
 * the mixer feeds the palette, and the host latch sets scroll, flip and enable.
 */
`timescale 1ns/1ps

module performan_video
	import video_pkg::*, ctrl_pkg::*;
#(
	parameter int H_TOTAL      = H_TOTAL_DEF,
	parameter int H_ACTIVE     = H_ACTIVE_DEF,
	parameter int H_SYNC_START = H_SYNC_START_DEF,
	parameter int H_SYNC_END   = H_SYNC_END_DEF,
	parameter int V_TOTAL      = V_TOTAL_DEF,
	parameter int V_ACTIVE     = V_ACTIVE_DEF,
	parameter int V_SYNC_START = V_SYNC_START_DEF,
	parameter int V_SYNC_END   = V_SYNC_END_DEF
) (
	input  logic                pixel_clk,
	input  logic                RESET_n,
	input  logic                reg_wr_i,   // Host register strobe
	input  logic [REG_OP_W-1:0] reg_addr_i,
	input  reg_data_t           reg_data_i,
	input  logic [9:0]          dn_addr_i,  // Palette download
	input  channel_t            dn_data_i,
	input  logic                dn_wr_i,
	input  pix_t                bg_pix_i,
	input  pix_t                sp_pix_i,
	output hcount_t             hpix_scrl_o,
	output channel_t            red_o,
	output channel_t            green_o,
	output channel_t            blue_o,
	output logic                hsync_o,
	output logic                vsync_o,
	output logic                hblank_o,
	output logic                vblank_o
);

	hcount_t hscroll;
	logic    flip;
	logic    video_en;

	video_timing_if tm_if ();
	pixel_stream_if ps_if ();

	// ==============================
	// Control and timing
	// ==============================
	io_latch i_io_latch (
		.pixel_clk  (pixel_clk),
		.RESET_n    (RESET_n),
		.reg_wr_i   (reg_wr_i),
		.reg_addr_i (reg_op_e'(reg_addr_i)),
		.reg_data_i (reg_data_i),
		.hscroll_o  (hscroll),
		.flip_o     (flip),
		.video_en_o (video_en)
	);

	video_timing #(
		.H_TOTAL      (H_TOTAL),
		.H_ACTIVE     (H_ACTIVE),
		.H_SYNC_START (H_SYNC_START),
		.H_SYNC_END   (H_SYNC_END),
		.V_TOTAL      (V_TOTAL),
		.V_ACTIVE     (V_ACTIVE),
		.V_SYNC_START (V_SYNC_START),
		.V_SYNC_END   (V_SYNC_END)
	) i_video_timing (
		.pixel_clk   (pixel_clk),
		.RESET_n     (RESET_n),
		.flip_i      (flip),
		.hscroll_i   (hscroll),
		.hpix_scrl_o (hpix_scrl_o),
		.tm          (tm_if.src)
	);

	// ==============================
	// Pixel path
	// ==============================
	priority_mixer i_priority_mixer (
		.pixel_clk  (pixel_clk),
		.RESET_n    (RESET_n),
		.video_en_i (video_en),
		.bg_pix_i   (bg_pix_i),
		.sp_pix_i   (sp_pix_i),
		.tm         (tm_if.snk),
		.ps         (ps_if.src)
	);

	colour_palette i_colour_palette (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.dn_addr_i (dn_addr_i),
		.dn_data_i (dn_data_i),
		.dn_wr_i   (dn_wr_i),
		.ps        (ps_if.snk),
		.red_o     (red_o),
		.green_o   (green_o),
		.blue_o    (blue_o),
		.hsync_o   (hsync_o),
		.vsync_o   (vsync_o),
		.hblank_o  (hblank_o),
		.vblank_o  (vblank_o)
	);

endmodule

// ==== colour_palette.sv ====
/*
 * Downloadable 256 entry RGB palette. Downloads write one colour plane per
 * strobe; the lookup registers RGB together with sync and blank.
 */
`timescale 1ns/1ps

module colour_palette
	import video_pkg::*;
(
	input  logic        pixel_clk,
	input  logic        RESET_n,
	input  logic [9:0]  dn_addr_i,
	input  channel_t    dn_data_i,
	input  logic        dn_wr_i,
	pixel_stream_if.snk ps,
	output channel_t    red_o,
	output channel_t    green_o,
	output channel_t    blue_o,
	output logic        hsync_o,
	output logic        vsync_o,
	output logic        hblank_o,
	output logic        vblank_o
);

	channel_t    red_tab   [2**IDX_W];
	channel_t    green_tab [2**IDX_W];
	channel_t    blue_tab  [2**IDX_W];
	plane_e      dn_plane;
	colour_idx_t dn_idx;
	logic [11:0] dn_probe; // Entry at the download index

	assign dn_plane = plane_e'(dn_addr_i[9:8]);
	assign dn_idx   = dn_addr_i[7:0];
	assign dn_probe = {red_tab[dn_idx], green_tab[dn_idx], blue_tab[dn_idx]};

	// Download port
	always_ff @(posedge pixel_clk) begin
		if (dn_wr_i) begin
			case (dn_plane)
				RED_PLANE:   red_tab[dn_idx]   <= dn_data_i;
				GREEN_PLANE: green_tab[dn_idx] <= dn_data_i;
				BLUE_PLANE:  blue_tab[dn_idx]  <= dn_data_i;
				default:     ;
			endcase
		end
	end

	// ==============================
	// Stage T+2 lookup
	// ==============================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			red_o    <= '0;
			green_o  <= '0;
			blue_o   <= '0;
			hsync_o  <= 1'b0;
			vsync_o  <= 1'b0;
			hblank_o <= 1'b0;
			vblank_o <= 1'b0;
		end else begin
			red_o    <= red_tab[ps.colour_idx];
			green_o  <= green_tab[ps.colour_idx];
			blue_o   <= blue_tab[ps.colour_idx];
			hsync_o  <= ps.hsync;
			vsync_o  <= ps.vsync;
			hblank_o <= ps.hblank;
			vblank_o <= ps.vblank;
		end
	end

	// Entry read back one cycle later is unchanged
	a_plane3_ignored: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(dn_wr_i && dn_addr_i[9:8] == 2'b11) |=>
		({red_tab[$past(dn_idx)], green_tab[$past(dn_idx)], blue_tab[$past(dn_idx)]}
		 == $past(dn_probe)));

endmodule

// ==== priority_mixer.sv ====
/*
 * Chooses sprite or background per pixel and forces index 0 in blank or when
 * video is disabled. Registers the index with a copy of the timing.
 */
`timescale 1ns/1ps

module priority_mixer
	import video_pkg::*;
(
	input  logic        pixel_clk,
	input  logic        RESET_n,
	input  logic        video_en_i,
	input  pix_t        bg_pix_i,
	input  pix_t        sp_pix_i,
	video_timing_if.snk tm,
	pixel_stream_if.src ps
);

	logic        sp_opaque;
	logic        sp_wins;
	colour_idx_t idx_next;

	// Transparency code 0 means no sprite here
	assign sp_opaque = |sp_pix_i[2:0];
	assign sp_wins   = sp_opaque && (sp_pix_i[7] || (bg_pix_i[2:0] == 3'b000));

	always_comb begin
		if (tm.hblank || tm.vblank || !video_en_i)
			idx_next = '0;
		else if (sp_wins)
			idx_next = {1'b1, sp_pix_i[6:0]}; // Upper half of palette
		else
			idx_next = bg_pix_i;
	end

	// ==============================
	// Stage T+1
	// ==============================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			ps.colour_idx <= '0;
			ps.hblank     <= 1'b0;
			ps.vblank     <= 1'b0;
			ps.hsync      <= 1'b0;
			ps.vsync      <= 1'b0;
		end else begin
			ps.colour_idx <= idx_next;
			ps.hblank     <= tm.hblank;
			ps.vblank     <= tm.vblank;
			ps.hsync      <= tm.hsync;
			ps.vsync      <= tm.vsync;
		end
	end

	// Blank at stage T must give a zero index at T+1
	a_blank_idx: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(tm.hblank || tm.vblank) |=> (ps.colour_idx == '0));

endmodule

// ==== io_latch.sv ====
/*
 * Addressable control latch. A single-cycle host strobe writes the register
 * picked by the opcode; the other registers hold.
 */
`timescale 1ns/1ps

module io_latch
	import video_pkg::*, ctrl_pkg::*;
(
	input  logic      pixel_clk,
	input  logic      RESET_n,
	input  logic      reg_wr_i,
	input  reg_op_e   reg_addr_i,
	input  reg_data_t reg_data_i,
	output hcount_t   hscroll_o,
	output logic      flip_o,
	output logic      video_en_o
);

	hcount_t hscroll;
	logic    flip;
	logic    video_en;

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hscroll  <= '0;
			flip     <= 1'b0;
			video_en <= 1'b0; // Screen dark until the host enables it
		end else if (reg_wr_i) begin
			case (reg_addr_i)
				REG_HSCROLL_LO: hscroll[7:0] <= reg_data_i;
				REG_HSCROLL_HI: hscroll[8]   <= reg_data_i[0];
				REG_FLIP:       flip         <= reg_data_i[0];
				REG_VIDEO_EN:   video_en     <= reg_data_i[0];
				default:        ;             // Unused codes
			endcase
		end
	end

	assign hscroll_o  = hscroll;
	assign flip_o     = flip;
	assign video_en_o = video_en;

endmodule

// ==== video_timing.sv ====
/*
 * Pixel and line counters with sync and blank decode, plus the horizontal
 * scroll adder feeding the background fetch. All outputs are registered.
 */
`timescale 1ns/1ps

module video_timing
	import video_pkg::*;
#(
	parameter int H_TOTAL      = H_TOTAL_DEF,
	parameter int H_ACTIVE     = H_ACTIVE_DEF,
	parameter int H_SYNC_START = H_SYNC_START_DEF,
	parameter int H_SYNC_END   = H_SYNC_END_DEF,
	parameter int V_TOTAL      = V_TOTAL_DEF,
	parameter int V_ACTIVE     = V_ACTIVE_DEF,
	parameter int V_SYNC_START = V_SYNC_START_DEF,
	parameter int V_SYNC_END   = V_SYNC_END_DEF
) (
	input  logic        pixel_clk,
	input  logic        RESET_n,
	input  logic        flip_i,
	input  hcount_t     hscroll_i,
	output hcount_t     hpix_scrl_o,
	video_timing_if.src tm
);

	hcount_t    hcount;
	vcount_t    vcount;
	logic       h_wrap;
	hcount_t    pix_col;
	logic [4:0] sum_lo;  // Low nibble with carry
	logic [4:0] sum_hi;
	logic       sum_top;

	// ==============================
	// Counters
	// ==============================
	assign h_wrap = (hcount == hcount_t'(H_TOTAL - 1));

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hcount <= '0;
			vcount <= '0;
		end else if (h_wrap) begin
			hcount <= '0;
			if (vcount == vcount_t'(V_TOTAL - 1))
				vcount <= '0;
			else
				vcount <= vcount + 1'b1; // Line clock
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	// ==============================
	// Scroll adder
	// ==============================
	// Flip mirrors the active columns
	assign pix_col = flip_i ? hcount_t'(H_ACTIVE - 1) - hcount : hcount;

	// Nibble cascade, carry out of bit 8 is dropped
	assign sum_lo  = {1'b0, pix_col[3:0]} + {1'b0, hscroll_i[3:0]};
	assign sum_hi  = {1'b0, pix_col[7:4]} + {1'b0, hscroll_i[7:4]} + sum_lo[4];
	assign sum_top = pix_col[8] ^ hscroll_i[8] ^ sum_hi[4];

	// Stage T
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			tm.hblank   <= 1'b0;
			tm.vblank   <= 1'b0;
			tm.hsync    <= 1'b0;
			tm.vsync    <= 1'b0;
			hpix_scrl_o <= '0;
		end else begin
			tm.hblank   <= (hcount >= hcount_t'(H_ACTIVE));
			tm.hsync    <= (hcount >= hcount_t'(H_SYNC_START)) &&
			               (hcount < hcount_t'(H_SYNC_END));
			tm.vblank   <= (vcount >= vcount_t'(V_ACTIVE));
			tm.vsync    <= (vcount >= vcount_t'(V_SYNC_START)) &&
			               (vcount < vcount_t'(V_SYNC_END));
			hpix_scrl_o <= {sum_top, sum_hi[3:0], sum_lo[3:0]};
		end
	end

	a_hcount_range: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		hcount < hcount_t'(H_TOTAL));

endmodule

// ==== pixel_stream_if.sv ====
/*
 * Mixed palette index with its sync and blank, one pixel per clock,
 * from the priority mixer to the palette.
 */
`timescale 1ns/1ps

interface pixel_stream_if;

	logic [7:0] colour_idx; // Palette index
	logic       hblank;
	logic       vblank;
	logic       hsync;
	logic       vsync;

	modport src (
		output colour_idx,
		output hblank, vblank,
		output hsync, vsync
	);

	modport snk (
		input colour_idx,
		input hblank, vblank,
		input hsync, vsync
	);

endinterface

// ==== video_timing_if.sv ====
/*
 * Registered raster timing from the timing generator to the mixer.
 * All signals are active high and change together.
 */
`timescale 1ns/1ps

interface video_timing_if;

	logic hblank;
	logic vblank;
	logic hsync;
	logic vsync;

	// Timing generator side
	modport src (
		output hblank,
		output vblank,
		output hsync,
		output vsync
	);

	// Mixer side
	modport snk (
		input hblank,
		input vblank,
		input hsync,
		input vsync
	);

endinterface

// ==== ctrl_pkg.sv ====
/*
 * Host register map of the video latch. Opcodes select which control
 * register a host write strobe updates.
 */
package ctrl_pkg;

	// ==============================
	// Register interface widths
	// ==============================
	localparam int REG_OP_W   = 3;
	localparam int REG_DATA_W = 8;

	typedef logic [REG_DATA_W-1:0] reg_data_t;

	// Codes 4 to 7 are ignored by the latch
	typedef enum logic [REG_OP_W-1:0] {
		REG_HSCROLL_LO = 3'd0, // Scroll bits 7..0
		REG_HSCROLL_HI = 3'd1, // Scroll bit 8 from data bit 0
		REG_FLIP       = 3'd2,
		REG_VIDEO_EN   = 3'd3
	} reg_op_e;

endpackage

// ==== video_pkg.sv ====
/*
 * Video timing defaults, pixel and colour widths and the pixel types shared
 * by the video back end. Modules take it with a wildcard import.
 */
package video_pkg;

	// ==============================
	// Default raster timing
	// ==============================
	localparam int H_TOTAL_DEF      = 384; // Pixels per line
	localparam int H_ACTIVE_DEF     = 256;
	localparam int H_SYNC_START_DEF = 288;
	localparam int H_SYNC_END_DEF   = 320;

	localparam int V_TOTAL_DEF      = 264; // Lines per frame
	localparam int V_ACTIVE_DEF     = 240;
	localparam int V_SYNC_START_DEF = 248;
	localparam int V_SYNC_END_DEF   = 256;

	// ==============================
	// Widths
	// ==============================
	localparam int HCOUNT_W = 9;
	localparam int VCOUNT_W = 9;
	localparam int PIX_W    = 8;
	localparam int IDX_W    = 8; // 256 palette entries
	localparam int CHAN_W   = 4; // 12 bit RGB

	typedef logic [HCOUNT_W-1:0] hcount_t;     // Also the scrolled column
	typedef logic [VCOUNT_W-1:0] vcount_t;
	typedef logic [PIX_W-1:0]    pix_t;        // Sprite bit 7 is priority
	typedef logic [IDX_W-1:0]    colour_idx_t;
	typedef logic [CHAN_W-1:0]   channel_t;

	// Plane field of a download address, code 3 unused
	typedef enum logic [1:0] {
		RED_PLANE   = 2'd0,
		GREEN_PLANE = 2'd1,
		BLUE_PLANE  = 2'd2
	} plane_e;

endpackage
